//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f tb.f --top-module tb_mac_rx -o sim_mac_rx

out=$(./obj_dir/sim_mac_rx)
echo "$out"

if grep -qx "Regression passed" <<< "$out"; then
    exit 0
fi
exit 1

//--- src/apb_host_port.sv
`timescale 1ns/10ps

module apb_host_port
    import frame_pkg::*;
    import buf_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_aw-1:0] paddr,
    input  logic [31:0]       pwdata,
    input  logic              frame_ready,
    input  logic [buf_aw-1:0] frame_len,
    input  logic [byte_w-1:0] frame_type,
    input  logic              ack_needed,
    input  logic              ack_received,
    input  logic [byte_w-1:0] ack_addr,
    input  logic [cnt_w-1:0]  err_count,
    input  logic [cnt_w-1:0]  drop_count,
    input  logic              rd_valid,
    input  logic [byte_w-1:0] rd_data,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              buf_release,
    output logic              clr_ack_rcv,
    output logic              clr_counts,
    output logic              rd_req,
    output logic [buf_aw-1:0] rd_addr
);

    logic setup, win_hit, reg_hit, rd_pend, ctl_wr;
    logic [apb_aw-1:0] win_off;
    logic [31:0] reg_word;

    assign setup = psel && !penable;

    // window covers 4 bytes of address per buffer byte
    assign win_off = paddr - win_base;
    assign win_hit = (paddr >= win_base) && (win_off[apb_aw-1:2] < buf_depth);
    assign reg_hit = paddr inside {reg_status, reg_length, reg_control, reg_ack_addr};

    always_comb begin
        case (paddr)
            reg_status: reg_word = {16'h0, drop_count, err_count,
                                    5'h0, ack_received, ack_needed, frame_ready};
            reg_length: reg_word = {8'h0, frame_type, 7'h0, frame_len};
            reg_ack_addr: reg_word = {24'h0, ack_addr};
            // control reads back zero, unmapped too
            default: reg_word = '0;
        endcase
    end

    // response registered in setup, so pready is up in the first access cycle
    // window reads wait for the arbiter instead
    always_ff @(posedge clk) begin
        if (rst) begin
            pready <= 1'b0;
            pslverr <= 1'b0;
            prdata <= '0;
            rd_pend <= 1'b0;
        end else begin
            pready <= 1'b0;
            pslverr <= 1'b0;
            if (setup) begin
                if (win_hit && !pwrite) begin
                    rd_pend <= 1'b1;
                end else begin
                    pready <= 1'b1;
                    // window and unmapped writes are refused
                    pslverr <= pwrite && !reg_hit;
                    if (!pwrite) begin
                        prdata <= reg_word;
                    end
                end
            end
            if (rd_pend && rd_valid) begin
                rd_pend <= 1'b0;
                pready <= 1'b1;
                prdata <= {{(32 - byte_w){1'b0}}, rd_data};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setup && win_hit) begin
            rd_addr <= win_off[buf_aw+1:2];
        end
    end

    // drop the request as the data comes back, no second grant
    assign rd_req = rd_pend && !rd_valid;

    // control pulses on the completing access cycle only
    assign ctl_wr = psel && penable && pwrite && pready && (paddr == reg_control);
    assign buf_release = ctl_wr && pwdata[ctl_release];
    assign clr_ack_rcv = ctl_wr && pwdata[ctl_clr_ack];
    assign clr_counts = ctl_wr && pwdata[ctl_clr_cnt];

endmodule

//--- src/buf_arbiter.sv
`timescale 1ns/10ps

module buf_arbiter
    import frame_pkg::*;
    import buf_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_req,
    input  logic [buf_aw-1:0] wr_addr,
    input  logic [byte_w-1:0] wr_data,
    input  logic              rd_req,
    input  logic [buf_aw-1:0] rd_addr,
    output logic              rd_valid,
    output logic [byte_w-1:0] rd_data,
    output logic              ram_en,
    output logic              ram_we,
    output logic [buf_aw-1:0] ram_addr,
    output logic [byte_w-1:0] ram_wdata,
    input  logic [byte_w-1:0] ram_rdata
);

    logic rd_grant;

    // writer always wins, receiver has no stall path
    assign rd_grant = rd_req && !wr_req;

    assign ram_en = wr_req || rd_req;
    assign ram_we = wr_req;
    assign ram_addr = wr_req ? wr_addr : rd_addr;
    assign ram_wdata = wr_data;

    // ram read data lands the cycle after the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_grant;
        end
    end

    assign rd_data = ram_rdata;

endmodule

//--- src/buf_pkg.sv
package buf_pkg;

    // frame buffer geometry
    localparam int buf_depth = 512;
    localparam int buf_aw = 9;

    // error and drop counters, saturating
    localparam int cnt_w = 4;

    // apb register map
    localparam int apb_aw = 12;
    localparam logic [apb_aw-1:0] reg_status = 12'h000;
    localparam logic [apb_aw-1:0] reg_length = 12'h004;
    localparam logic [apb_aw-1:0] reg_control = 12'h008;
    localparam logic [apb_aw-1:0] reg_ack_addr = 12'h00c;

    // byte window, one buffer byte per word in bits 7:0
    localparam logic [apb_aw-1:0] win_base = 12'h400;

    // control register write bits
    localparam int ctl_release = 0;
    localparam int ctl_clr_ack = 1;
    localparam int ctl_clr_cnt = 2;

endpackage

//--- src/crc8_check.sv
`timescale 1ns/10ps

module crc8_check
    import frame_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              crc_clr,
    input  logic              crc_en,
    input  logic [byte_w-1:0] data,
    output logic [byte_w-1:0] residue
);

    logic [byte_w-1:0] crc_q;

    // fold one byte into the remainder, msb first
    function automatic logic [byte_w-1:0] crc_step(
        input logic [byte_w-1:0] crc,
        input logic [byte_w-1:0] din
    );
        logic [byte_w-1:0] r;
        r = crc ^ din;
        for (int i = 0; i < byte_w; i++) begin
            if (r[byte_w-1]) begin
                r = (r << 1) ^ crc_poly;
            end else begin
                r = r << 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || crc_clr) begin
            crc_q <= '0;
        end else if (crc_en) begin
            crc_q <= crc_step(crc_q, data);
        end
    end

    // zero once the fcs byte has gone through
    assign residue = crc_q;

endmodule

//--- src/frame_pkg.sv
package frame_pkg;

    // one radio byte
    localparam int byte_w = 8;

    // destination that every station takes
    localparam logic [byte_w-1:0] bcast_addr = 8'h2a;

    // frame type codes, carried in the third byte
    // plain data, fcs not checked
    localparam logic [byte_w-1:0] type_plain = 8'h30;
    // data with fcs check
    localparam logic [byte_w-1:0] type_data = 8'h31;
    // data, sender wants an ack back
    localparam logic [byte_w-1:0] type_ack_req = 8'h32;
    // ack from a peer, no payload kept
    localparam logic [byte_w-1:0] type_ack = 8'h33;

    // header byte positions
    localparam int off_dest = 0;
    localparam int off_src = 1;
    localparam int off_type = 2;

    // crc-8, x^8 + x^2 + x + 1, msb first, init zero
    // run over the fcs too, so a clean frame ends at zero
    localparam logic [byte_w-1:0] crc_poly = 8'h07;

endpackage

//--- src/frame_ram.sv
`timescale 1ns/10ps

module frame_ram
    import frame_pkg::*;
    import buf_pkg::*;
(
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [buf_aw-1:0] addr,
    input  logic [byte_w-1:0] wdata,
    output logic [byte_w-1:0] rdata
);

    logic [byte_w-1:0] mem [buf_depth];

    // single port, registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- src/mac_rx_top.sv
`timescale 1ns/10ps

module mac_rx_top
    import frame_pkg::*;
    import buf_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_valid,
    input  logic [byte_w-1:0] rx_data,
    input  logic              cardet,
    input  logic [byte_w-1:0] station_addr,
    input  logic              ack_sent,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_aw-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              ack_needed,
    output logic [byte_w-1:0] ack_addr
);

    // receiver write side
    logic              wr_req;
    logic [buf_aw-1:0] wr_addr;
    logic [byte_w-1:0] wr_data;
    // host read side
    logic              rd_req, rd_valid;
    logic [buf_aw-1:0] rd_addr;
    logic [byte_w-1:0] rd_data;
    // ram port
    logic              ram_en, ram_we;
    logic [buf_aw-1:0] ram_addr;
    logic [byte_w-1:0] ram_wdata, ram_rdata;
    // status and control
    logic              frame_ready, ack_received;
    logic              buf_release, clr_ack_rcv, clr_counts;
    logic [buf_aw-1:0] frame_len;
    logic [byte_w-1:0] frame_type;
    logic [cnt_w-1:0]  err_count, drop_count;

    rx_frame_ctrl ctrl0 (
        .clk, .rst, .rx_valid, .rx_data, .cardet, .station_addr, .ack_sent,
        .buf_release, .clr_ack_rcv, .clr_counts,
        .wr_req, .wr_addr, .wr_data,
        .frame_ready, .frame_len, .frame_type,
        .ack_needed, .ack_received, .ack_addr,
        .err_count, .drop_count
    );

    buf_arbiter arb0 (
        .clk, .rst, .wr_req, .wr_addr, .wr_data,
        .rd_req, .rd_addr, .rd_valid, .rd_data,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    frame_ram ram0 (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    apb_host_port apb0 (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .frame_ready, .frame_len, .frame_type,
        .ack_needed, .ack_received, .ack_addr,
        .err_count, .drop_count, .rd_valid, .rd_data,
        .prdata, .pready, .pslverr,
        .buf_release, .clr_ack_rcv, .clr_counts,
        .rd_req, .rd_addr
    );

endmodule

//--- src/rx_frame_ctrl.sv
`timescale 1ns/10ps

module rx_frame_ctrl
    import frame_pkg::*;
    import buf_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_valid,
    input  logic [byte_w-1:0] rx_data,
    input  logic              cardet,
    input  logic [byte_w-1:0] station_addr,
    input  logic              ack_sent,
    input  logic              buf_release,
    input  logic              clr_ack_rcv,
    input  logic              clr_counts,
    output logic              wr_req,
    output logic [buf_aw-1:0] wr_addr,
    output logic [byte_w-1:0] wr_data,
    output logic              frame_ready,
    output logic [buf_aw-1:0] frame_len,
    output logic [byte_w-1:0] frame_type,
    output logic              ack_needed,
    output logic              ack_received,
    output logic [byte_w-1:0] ack_addr,
    output logic [cnt_w-1:0]  err_count,
    output logic [cnt_w-1:0]  drop_count
);

    typedef enum logic [1:0] {st_idle, st_filter, st_store, st_decide} state_t;
    state_t state;

    logic [buf_aw-1:0] wr_cnt;
    logic [byte_w-1:0] dest_q, src_q, type_q;
    logic [byte_w-1:0] residue;
    logic addr_hit, hit, keep, crc_ok;
    logic set_ready, set_ack_need, set_ack_rcv, inc_err, inc_drop;

    // first byte is ours or broadcast
    assign addr_hit = (rx_data == station_addr) || (rx_data == bcast_addr);

    // filter writes byte 0 only when the buffer is free
    // store stops one short of wrapping so the length fits buf_aw bits
    always_comb begin
        if (state == st_filter) begin
            wr_req = rx_valid && addr_hit && !frame_ready;
        end else begin
            wr_req = (state == st_store) && rx_valid && keep && (wr_cnt != '1);
        end
    end
    assign wr_addr = wr_cnt;
    assign wr_data = rx_data;

    crc8_check crc0 (
        .clk     (clk),
        .rst     (rst),
        .crc_clr (state == st_idle),
        .crc_en  (wr_req),
        .data    (rx_data),
        .residue (residue)
    );

    assign crc_ok = (residue == '0);

    // end-of-frame decision, one cycle in st_decide
    always_comb begin
        set_ready = 1'b0;
        set_ack_need = 1'b0;
        set_ack_rcv = 1'b0;
        inc_err = 1'b0;
        inc_drop = 1'b0;
        if (state == st_decide) begin
            if (hit && !keep) begin
                // addressed to us but buffer was busy
                inc_drop = 1'b1;
            end else if (keep) begin
                case (type_q)
                    type_plain: set_ready = 1'b1;
                    type_data: begin
                        set_ready = crc_ok;
                        inc_err = !crc_ok;
                    end
                    type_ack_req: begin
                        set_ready = crc_ok;
                        // no ack owed for broadcast
                        set_ack_need = crc_ok && (dest_q != bcast_addr);
                        inc_err = !crc_ok;
                    end
                    type_ack: begin
                        set_ack_rcv = crc_ok;
                        inc_err = !crc_ok;
                    end
                    // unknown types dropped without a trace
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            wr_cnt <= '0;
            hit <= 1'b0;
            keep <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    wr_cnt <= '0;
                    if (cardet) begin
                        state <= st_filter;
                    end
                end
                st_filter: begin
                    if (!cardet) begin
                        state <= st_idle;
                    end else if (rx_valid) begin
                        // foreign frames ride through store unwritten
                        hit <= addr_hit;
                        keep <= wr_req;
                        state <= st_store;
                    end
                end
                st_store: begin
                    if (!cardet) begin
                        state <= st_decide;
                    end
                end
                default: state <= st_idle;
            endcase
            if (wr_req) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // header capture
    always_ff @(posedge clk) begin
        if (state == st_filter) begin
            // short frames keep an unknown type
            type_q <= '0;
        end
        if (wr_req && wr_cnt == buf_aw'(off_dest)) begin
            dest_q <= rx_data;
        end
        if (wr_req && wr_cnt == buf_aw'(off_src)) begin
            src_q <= rx_data;
        end
        if (wr_req && wr_cnt == buf_aw'(off_type)) begin
            type_q <= rx_data;
        end
    end

    // host-visible frame info, held while ready
    always_ff @(posedge clk) begin
        if (set_ready) begin
            frame_len <= wr_cnt;
            frame_type <= type_q;
        end
        if (set_ack_need) begin
            ack_addr <= src_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_ready <= 1'b0;
            ack_needed <= 1'b0;
            ack_received <= 1'b0;
            err_count <= '0;
            drop_count <= '0;
        end else begin
            if (set_ready) begin
                frame_ready <= 1'b1;
            end else if (buf_release) begin
                frame_ready <= 1'b0;
            end
            if (set_ack_need) begin
                ack_needed <= 1'b1;
            end else if (ack_sent) begin
                ack_needed <= 1'b0;
            end
            if (set_ack_rcv) begin
                ack_received <= 1'b1;
            end else if (clr_ack_rcv) begin
                ack_received <= 1'b0;
            end
            // counters stick at all ones
            if (clr_counts) begin
                err_count <= '0;
                drop_count <= '0;
            end else begin
                if (inc_err && err_count != '1) begin
                    err_count <= err_count + 1'b1;
                end
                if (inc_drop && drop_count != '1) begin
                    drop_count <= drop_count + 1'b1;
                end
            end
        end
    end

endmodule

//--- tb.f
src/frame_pkg.sv
src/buf_pkg.sv
src/crc8_check.sv
src/rx_frame_ctrl.sv
src/buf_arbiter.sv
src/frame_ram.sv
src/apb_host_port.sv
src/mac_rx_top.sv
tests/tb_mac_rx.sv

//--- tests/tb_mac_rx.sv
`timescale 1ns/10ps

module tb_mac_rx
    import frame_pkg::*;
    import buf_pkg::*;
;

    // 5 tests of under 40 bytes at 4 cycles a byte, ~200 apb accesses,
    // times a wide margin: 20000 cycles, 2 ms at 100 ns
    localparam int wd_cycles = 20000;
    localparam logic [byte_w-1:0] stn = 8'h5c;

    logic              clk, rst;
    logic              rx_valid, cardet, ack_sent;
    logic [byte_w-1:0] rx_data, station_addr;
    logic              psel, penable, pwrite;
    logic [apb_aw-1:0] paddr;
    logic [31:0]       pwdata, prdata;
    logic              pready, pslverr, ack_needed;
    logic [byte_w-1:0] ack_addr;

    // expected controller state, kept from the frame rules
    logic              exp_ready, exp_ackn, exp_ackr;
    logic [cnt_w-1:0]  exp_err, exp_drop;
    // stored length of the last frame that became ready
    logic [buf_aw-1:0] good_len;
    logic [15:0]       lfsr_q;
    logic [byte_w-1:0] frame_q[$];
    logic [byte_w-1:0] keep_q[$];
    int                errors;

    mac_rx_top dut0 (
        .clk, .rst, .rx_valid, .rx_data, .cardet, .station_addr, .ack_sent,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .ack_needed, .ack_addr
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", wd_cycles);
        $display("errors: %0d", errors);
        $display("Regression failed");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one step per bit taken
    task automatic next_payload_byte(output logic [byte_w-1:0] b);
        b = '0;
        for (int k = 0; k < byte_w; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b = {b[byte_w-2:0], lfsr_q[0]};
        end
    endtask

    // bit-serial crc-8 over the first n bytes of frame_q
    function automatic logic [byte_w-1:0] crc8_ref(input int n);
        logic [byte_w-1:0] c;
        logic fb;
        c = '0;
        for (int i = 0; i < n; i++) begin
            for (int k = byte_w - 1; k >= 0; k--) begin
                fb = c[byte_w-1] ^ frame_q[i][k];
                c = {c[byte_w-2:0], 1'b0};
                if (fb) c = c ^ crc_poly;
            end
        end
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("Fail %s: expected %h, actual %h", name, exp, got);
        errors++;
    endtask

    // header plus random payload, fcs added at send time
    task automatic build_frame(input logic [byte_w-1:0] dest, input logic [byte_w-1:0] src,
                               input logic [byte_w-1:0] typ, input int n);
        logic [byte_w-1:0] b;
        frame_q.delete();
        frame_q.push_back(dest);
        frame_q.push_back(src);
        frame_q.push_back(typ);
        repeat (n) begin
            next_payload_byte(b);
            frame_q.push_back(b);
        end
    endtask

    // flip_at corrupts one byte on the air only, -1 for none
    task automatic send_frame(input int flip_at);
        logic [byte_w-1:0] b;
        frame_q.push_back(crc8_ref(frame_q.size()));
        cardet = 1'b1;
        @(negedge clk);
        for (int i = 0; i < frame_q.size(); i++) begin
            b = frame_q[i];
            if (i == flip_at) b = b ^ 8'h01;
            rx_valid = 1'b1;
            rx_data = b;
            @(negedge clk);
            rx_valid = 1'b0;
            repeat (3) @(negedge clk);
        end
        cardet = 1'b0;
        // decision lands 2 cycles after carrier drop
        repeat (2) @(negedge clk);
    endtask

    // access phase already driven, pready sampled mid-cycle
    task automatic await_pready(input logic [apb_aw-1:0] addr);
        int waited;
        waited = 0;
        while (!pready && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("apb transfer to %h never completed", addr);
            errors++;
        end
    endtask

    task automatic apb_read(input logic [apb_aw-1:0] addr, output logic [31:0] data);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        await_pready(addr);
        data = prdata;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [31:0] data,
                             output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        await_pready(addr);
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic check_status(input string name);
        logic [31:0] exp, got;
        exp = {16'h0, exp_drop, exp_err, 5'h0, exp_ackr, exp_ackn, exp_ready};
        apb_read(reg_status, got);
        if (got !== exp) report_mismatch({name, " status"}, exp, got);
    endtask

    task automatic check_length(input string name, input logic [byte_w-1:0] typ);
        logic [31:0] exp, got;
        exp = {8'h0, typ, 7'h0, buf_aw'(frame_q.size())};
        apb_read(reg_length, got);
        if (got !== exp) report_mismatch({name, " length"}, exp, got);
    endtask

    // first n stored bytes against frame_q
    task automatic check_window(input string name, input int n);
        logic [31:0] got;
        for (int i = 0; i < n; i++) begin
            apb_read(win_base + apb_aw'(4 * i), got);
            if (got !== {24'h0, frame_q[i]}) begin
                report_mismatch({name, " window"}, {24'h0, frame_q[i]}, got);
            end
        end
    endtask

    task automatic test_good_frame();
        logic err;
        build_frame(stn, 8'h11, type_data, 20);
        send_frame(-1);
        exp_ready = 1'b1;
        good_len = buf_aw'(frame_q.size());
        check_status("good_frame");
        check_length("good_frame", type_data);
        check_window("good_frame", frame_q.size());
        // window is read only
        apb_write(win_base, 32'h0, err);
        if (err !== 1'b1) report_mismatch("good_frame pslverr", 32'h1, {31'h0, err});
        apb_write(reg_control, 32'h1, err);
        exp_ready = 1'b0;
        check_status("good_frame released");
    endtask

    task automatic test_crc_error();
        logic err;
        build_frame(stn, 8'h12, type_data, 10);
        send_frame(5);
        exp_err = 4'd1;
        check_status("crc_error");
        apb_write(reg_control, 32'h4, err);
        exp_err = 4'd0;
        check_status("crc_error cleared");
    endtask

    task automatic test_filter();
        logic [31:0] len_after;
        logic err;
        build_frame(8'h77, 8'h13, type_data, 8);
        send_frame(-1);
        check_status("foreign");
        // only a ready frame moves the length register
        apb_read(reg_length, len_after);
        if (len_after !== {8'h0, type_data, 7'h0, good_len}) begin
            report_mismatch("foreign length", {8'h0, type_data, 7'h0, good_len}, len_after);
        end
        // plain broadcast is kept with a bad fcs
        build_frame(bcast_addr, 8'h14, type_plain, 6);
        send_frame(frame_q.size());
        exp_ready = 1'b1;
        check_status("bcast_plain");
        check_length("bcast_plain", type_plain);
        apb_write(reg_control, 32'h1, err);
        exp_ready = 1'b0;
    endtask

    task automatic test_ack();
        logic [31:0] got;
        logic err;
        build_frame(stn, 8'h44, type_ack_req, 5);
        send_frame(-1);
        exp_ready = 1'b1;
        exp_ackn = 1'b1;
        check_status("ack_req");
        apb_read(reg_ack_addr, got);
        if (got !== 32'h44) report_mismatch("ack_req ack_addr reg", 32'h44, got);
        if (ack_addr !== 8'h44) report_mismatch("ack_req ack_addr port", 32'h44, {24'h0, ack_addr});
        if (ack_needed !== 1'b1) begin
            report_mismatch("ack_req ack_needed port", 32'h1, {31'h0, ack_needed});
        end
        ack_sent = 1'b1;
        @(negedge clk);
        ack_sent = 1'b0;
        if (ack_needed !== 1'b0) report_mismatch("ack_sent", 32'h0, {31'h0, ack_needed});
        exp_ackn = 1'b0;
        apb_write(reg_control, 32'h1, err);
        // broadcast owes no ack
        build_frame(bcast_addr, 8'h45, type_ack_req, 5);
        send_frame(-1);
        check_status("bcast_ack_req");
        apb_write(reg_control, 32'h1, err);
        exp_ready = 1'b0;
        build_frame(stn, 8'h46, type_ack, 0);
        send_frame(-1);
        exp_ackr = 1'b1;
        check_status("ack_frame");
        apb_write(reg_control, 32'h2, err);
        exp_ackr = 1'b0;
        check_status("ack_frame cleared");
    endtask

    task automatic test_drop_and_live_read();
        logic err;
        build_frame(stn, 8'h21, type_data, 12);
        send_frame(-1);
        exp_ready = 1'b1;
        keep_q = frame_q;
        build_frame(bcast_addr, 8'h22, type_data, 9);
        send_frame(-1);
        exp_drop = 4'd1;
        check_status("drop");
        // buffer still holds the first frame
        frame_q = keep_q;
        check_length("drop", type_data);
        check_window("drop", frame_q.size());
        apb_write(reg_control, 32'h1, err);
        exp_ready = 1'b0;
        build_frame(stn, 8'h23, type_data, 24);
        fork
            send_frame(-1);
            begin
                // bytes 0 to 6 are in by now
                // byte 7 is written in the first read's grant cycle, so that read waits
                repeat (28) @(negedge clk);
                check_window("live_read", 4);
            end
        join
        exp_ready = 1'b1;
        check_status("after_release");
        check_length("after_release", type_data);
    endtask

    initial begin
        errors = 0;
        lfsr_q = 16'd42901;
        exp_ready = 1'b0;
        exp_ackn = 1'b0;
        exp_ackr = 1'b0;
        exp_err = '0;
        exp_drop = '0;
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_data = '0;
        cardet = 1'b0;
        station_addr = stn;
        ack_sent = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_good_frame();
        test_crc_error();
        test_filter();
        test_ack();
        test_drop_and_live_read();
        $display("tests run: %0d, errors: %0d", 5, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
